// File: Bender.yml
package:
  name: bp_top

sources:
  - include_dirs:
      - common
    files:
      - common/bp_pkg.sv
      - common/bp_retire_if.sv
      - branch_predictor/branch_predictor.sv
      - logic/mispredict_check.sv
      - logic/fetch_pc_gen.sv
      - logic/bp_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/bp_tb.sv

// File: bench/bp_tb.sv
// ====================
// branch prediction testbench
// random stimulus checked against a model
// of the tables, fetch pc and mispredict checker
// ====================
`timescale 1ns/100ps
`include "bp_defines.svh"

module bp_tb;

    logic               i_clk;
    logic               i_rst_n;
    logic               fetch_en;
    bp_pkg::inst_type_t dispatch_inst_type;
    bp_pkg::inst_type_t retire_inst_type;
    bp_pkg::pc_t        retire_pc;
    logic               retire_taken;
    bp_pkg::target_t    retire_target;
    bp_pkg::pc_t        fetch_pc;
    logic               prediction;
    bp_pkg::target_t    predicted_target;
    logic               redirect;
    bp_pkg::pc_t        redirect_pc;
    bp_pkg::count_t     mispredict_count;

    // model of the tables, fetch pc and checker registers
    logic               m_hist [`BP_ENTRIES];
    bp_pkg::target_t    m_tgt  [`BP_ENTRIES];
    bp_pkg::pc_t        m_pc;
    logic               m_redirect;
    bp_pkg::pc_t        m_redirect_pc;
    bp_pkg::count_t     m_count;

    int errors;
    int test_start_errors;
    int tests_run;
    int tests_failed;

    bp_top u_dut (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .fetch_en           (fetch_en),
        .dispatch_inst_type (dispatch_inst_type),
        .retire_inst_type   (retire_inst_type),
        .retire_pc          (retire_pc),
        .retire_taken       (retire_taken),
        .retire_target      (retire_target),
        .fetch_pc           (fetch_pc),
        .prediction         (prediction),
        .predicted_target   (predicted_target),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .mispredict_count   (mispredict_count)
    );

    // 40 ns clock
    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // overall run limit
    initial begin
        #200000;
        $display("simulation ran past its time limit before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic bp_pkg::pc_t rand_addr();
        return $urandom & 32'h0000_fffc;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_hist[i] = 1'b0;
            m_tgt[i]  = '0;
        end
        m_pc          = `BP_RESET_PC;
        m_redirect    = 1'b0;
        m_redirect_pc = '0;
        m_count       = '0;
    endtask

    // one rising edge of the model, inputs as held over the cycle
    task automatic model_edge();
        bp_pkg::bp_index_t ridx;
        bp_pkg::bp_index_t didx;
        logic              old_bit;
        bp_pkg::target_t   old_tgt;
        logic              pred;
        logic              misp;
        logic              ret_br;
        ridx    = retire_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
        didx    = m_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
        ret_br  = (retire_inst_type == `INST_BRANCH);
        // table state before this edge's write
        old_bit = m_hist[ridx];
        old_tgt = m_tgt[ridx];
        pred    = (dispatch_inst_type == `INST_BRANCH) && m_hist[didx];
        misp    = ret_br && ((old_bit != retire_taken) ||
                  (old_bit && retire_taken && (old_tgt != retire_target)));
        // next pc, redirect first
        if (m_redirect) begin
            m_pc = m_redirect_pc;
        end else if (fetch_en && pred) begin
            m_pc = m_tgt[didx];
        end else if (fetch_en) begin
            m_pc = m_pc + 32'd4;
        end
        m_redirect = misp;
        if (misp) begin
            m_redirect_pc = retire_taken ? retire_target : retire_pc + 32'd4;
            m_count       = m_count + 16'd1;
        end
        if (ret_br) begin
            m_hist[ridx] = retire_taken;
            m_tgt[ridx]  = retire_target;
        end
    endtask

    // all outputs against the model, inputs already applied
    task automatic check_all();
        bp_pkg::bp_index_t didx;
        logic              exp_pred;
        bp_pkg::target_t   exp_tgt;
        didx     = m_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
        exp_pred = 1'b0;
        exp_tgt  = '0;
        if (dispatch_inst_type == `INST_BRANCH) begin
            exp_pred = m_hist[didx];
            exp_tgt  = m_tgt[didx];
        end
        compare("fetch_pc", fetch_pc, m_pc);
        compare("prediction", prediction, exp_pred);
        compare("predicted_target", predicted_target, exp_tgt);
        compare("redirect", redirect, m_redirect);
        compare("redirect_pc", redirect_pc, m_redirect_pc);
        compare("mispredict_count", mispredict_count, m_count);
    endtask

    // one cycle: drive at edge + 2, check, then clock the model
    task automatic apply(input logic fe, input bp_pkg::inst_type_t dtype,
                         input bp_pkg::inst_type_t rtype, input bp_pkg::pc_t rpc,
                         input logic rtaken, input bp_pkg::target_t rtgt);
        fetch_en           = fe;
        dispatch_inst_type = dtype;
        retire_inst_type   = rtype;
        retire_pc          = rpc;
        retire_taken       = rtaken;
        retire_target      = rtgt;
        #1;
        check_all();
        @(posedge i_clk);
        model_edge();
        #2;
    endtask

    // no retire this cycle
    task automatic idle(input logic fe, input bp_pkg::inst_type_t dtype);
        apply(fe, dtype, `INST_OTHER, '0, 1'b0, '0);
    endtask

    // let a pending redirect pulse pass with fetch stalled
    task automatic drain();
        idle(1'b0, `INST_OTHER);
        idle(1'b0, `INST_OTHER);
    endtask

    task automatic walk_to_index(input bp_pkg::bp_index_t idx);
        int n;
        n = 0;
        while (fetch_pc[`BP_INDEX_MSB:`BP_INDEX_LSB] != idx && n < 2 * `BP_ENTRIES) begin
            idle(1'b1, `INST_OTHER);
            n++;
        end
        if (fetch_pc[`BP_INDEX_MSB:`BP_INDEX_LSB] != idx) begin
            $display("fetch pc did not reach table index %0d within %0d cycles", idx, n);
            errors++;
        end
    endtask

    task automatic wait_redirect(output logic seen);
        int n;
        n = 0;
        while (redirect !== 1'b1 && n < 8) begin
            idle(1'b0, `INST_BRANCH);
            n++;
        end
        seen = (redirect === 1'b1);
        if (!seen) begin
            $display("no redirect within 8 cycles of a forced mispredict");
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - test_start_errors;
        tests_run++;
        if (n == 0) begin
            $display("test %-20s ok", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed with %0d errors", name, n);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic               r_fe;
        bp_pkg::inst_type_t r_dtype;
        logic               r_taken;
        bp_pkg::pc_t        r_rpc;
        bp_pkg::target_t    r_rtgt;
        bp_pkg::target_t    tgt_b;
        bp_pkg::pc_t        alias_a;
        bp_pkg::pc_t        other_pc;
        bp_pkg::pc_t        prev_pc;
        bp_pkg::pc_t        exp_pc;
        bp_pkg::bp_index_t  idx;
        logic               seen;

        void'($urandom(45));
        errors             = 0;
        test_start_errors  = 0;
        tests_run          = 0;
        tests_failed       = 0;
        i_rst_n            = 1'b0;
        fetch_en           = 1'b0;
        dispatch_inst_type = `INST_OTHER;
        retire_inst_type   = `INST_OTHER;
        retire_pc          = '0;
        retire_taken       = 1'b0;
        retire_target      = '0;
        model_reset();
        repeat (3) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;

        // reset state, cleared table answers zero everywhere
        compare("fetch_pc after reset", fetch_pc, `BP_RESET_PC);
        compare("redirect after reset", redirect, 32'd0);
        compare("mispredict_count after reset", mispredict_count, 32'd0);
        for (int i = 0; i < 12; i++) begin
            idle(1'b1, `INST_BRANCH);
            compare("prediction from cleared table", prediction, 32'd0);
            compare("target from cleared table", predicted_target, 32'd0);
        end
        finish_test("reset state");

        // random updates and lookups
        for (int i = 0; i < 40; i++) begin
            r_fe    = $urandom % 2;
            r_dtype = $urandom % 4;
            r_taken = $urandom % 2;
            apply(r_fe, r_dtype, ($urandom % 2) ? `INST_BRANCH : `INST_OTHER,
                  rand_addr(), r_taken, rand_addr());
        end
        // two pcs on one index, last write wins
        drain();
        idx     = fetch_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
        alias_a = ($urandom & 32'h0000_ffe0) | {27'd0, idx, 2'b00};
        r_rtgt  = rand_addr();
        tgt_b   = r_rtgt ^ 32'h0000_0010;
        apply(1'b0, `INST_OTHER, `INST_BRANCH, alias_a, 1'b1, r_rtgt);
        apply(1'b0, `INST_OTHER, `INST_BRANCH, alias_a ^ 32'h0000_0100, 1'b0, tgt_b);
        drain();
        walk_to_index(idx);
        idle(1'b0, `INST_BRANCH);
        compare("aliased prediction", prediction, 32'd0);
        compare("aliased target", predicted_target, tgt_b);
        idle(1'b0, `INST_JUMP);
        compare("prediction for a jump", prediction, 32'd0);
        compare("target for a jump", predicted_target, 32'd0);
        finish_test("table update");

        // retired branches over a few pcs and two targets
        for (int i = 0; i < 60; i++) begin
            r_fe    = $urandom % 2;
            r_dtype = $urandom % 4;
            r_taken = $urandom % 2;
            r_rpc   = ($urandom & 32'h0000_003c) | 32'h0000_1000;
            r_rtgt  = ($urandom % 2) ? 32'h0000_2000 : 32'h0000_3000;
            apply(r_fe, r_dtype, `INST_BRANCH, r_rpc, r_taken, r_rtgt);
        end
        drain();
        compare("mispredict_count after random retires", mispredict_count, m_count);
        finish_test("mispredict detection");

        // sequential, stalled and predicted fetch
        for (int i = 0; i < 8; i++) begin
            prev_pc = fetch_pc;
            idle(1'b1, `INST_OTHER);
            compare("fetch_pc step by 4", fetch_pc, prev_pc + 32'd4);
        end
        for (int i = 0; i < 4; i++) begin
            prev_pc = fetch_pc;
            idle(1'b0, `INST_OTHER);
            compare("fetch_pc held while stalled", fetch_pc, prev_pc);
        end
        idx    = fetch_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
        r_rtgt = rand_addr() | 32'h0001_0000;
        apply(1'b0, `INST_OTHER, `INST_BRANCH, fetch_pc, 1'b1, r_rtgt);
        drain();
        walk_to_index(idx);
        idle(1'b0, `INST_BRANCH);
        compare("prediction after taken update", prediction, 32'd1);
        compare("target after taken update", predicted_target, r_rtgt);
        idle(1'b1, `INST_BRANCH);
        compare("fetch_pc follows prediction", fetch_pc, r_rtgt);
        finish_test("fetch sequencing");

        // fetch pc entry trained taken onto itself
        // redirect then contends with a stall or a taken prediction
        for (int i = 0; i < 3; i++) begin
            drain();
            r_fe     = i[0];
            r_rpc    = fetch_pc;
            other_pc = r_rpc ^ 32'h0000_0010;
            exp_pc   = other_pc + 32'd4;
            // training redirects land back on r_rpc
            apply(1'b0, `INST_OTHER, `INST_BRANCH, r_rpc, 1'b1, r_rpc);
            apply(1'b0, `INST_OTHER, `INST_BRANCH, other_pc, 1'b1, r_rpc);
            // not taken against a taken history bit
            apply(1'b0, `INST_OTHER, `INST_BRANCH, other_pc, 1'b0, r_rpc);
            wait_redirect(seen);
            if (seen) begin
                compare("redirect_pc falls through", redirect_pc, exp_pc);
                idle(r_fe, `INST_BRANCH);
                compare("fetch_pc after redirect", fetch_pc, exp_pc);
            end
        end
        idle(1'b0, `INST_OTHER);
        finish_test("redirect priority");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: bp_top.f
+incdir+common
common/bp_pkg.sv
common/bp_retire_if.sv
branch_predictor/branch_predictor.sv
logic/mispredict_check.sv
logic/fetch_pc_gen.sv
logic/bp_top.sv
bench/bp_tb.sv

// File: branch_predictor/branch_predictor.sv
// ====================
// branch predictor
// one-bit history table with target buffer
// combinational dispatch lookup, retire update and checkout
// ====================
`timescale 1ns/100ps
`include "bp_defines.svh"

module branch_predictor (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  bp_pkg::inst_type_t dispatch_inst_type,
    input  bp_pkg::pc_t        dispatch_pc,
    bp_retire_if.predictor     retire,
    output logic               prediction,
    output bp_pkg::target_t    predicted_target,
    output bp_pkg::target_t    retire_pred_target
);

    // one history bit per entry
    logic [`BP_ENTRIES-1:0] hist_bits;
    // target per entry, kept even when not taken
    bp_pkg::target_t        target_buf [`BP_ENTRIES];

    bp_pkg::bp_index_t      dispatch_idx;
    bp_pkg::bp_index_t      retire_idx;
    logic                   dispatch_is_branch;
    logic                   retire_is_branch;

    // no tags, aliasing pcs share an entry
    assign dispatch_idx = dispatch_pc[`BP_INDEX_MSB:`BP_INDEX_LSB];
    assign retire_idx   = retire.pc[`BP_INDEX_MSB:`BP_INDEX_LSB];

    assign dispatch_is_branch = (dispatch_inst_type == `INST_BRANCH);
    assign retire_is_branch   = (retire.inst_type == `INST_BRANCH);

    // update on every retired branch
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hist_bits <= '0;
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                target_buf[i] <= '0;
            end
        end else if (retire_is_branch) begin
            // last outcome wins
            hist_bits[retire_idx]  <= retire.taken;
            target_buf[retire_idx] <= retire.target;
        end
    end

    // dispatch lookup, same cycle
    // zero for anything but a branch
    assign prediction       = dispatch_is_branch ? hist_bits[dispatch_idx] : 1'b0;
    assign predicted_target = dispatch_is_branch ? target_buf[dispatch_idx] : '0;

    // retire checkout
    // reads the entry before this cycle's write lands
    assign retire.pred_taken  = retire_is_branch ? hist_bits[retire_idx] : 1'b0;
    assign retire_pred_target = retire_is_branch ? target_buf[retire_idx] : '0;

endmodule

// File: common/bp_defines.svh
// ====================
// branch prediction defines
// table geometry, reset PC and instruction type codes
// ====================
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// table geometry, indexed by pc[4:2]
`define BP_ENTRIES      8
`define BP_INDEX_LSB    2
`define BP_INDEX_MSB    4

// fetch address after reset
`define BP_RESET_PC     32'h0000_0000

// instruction type codes from decode
`define INST_OTHER      2'd0
`define INST_BRANCH     2'd1
`define INST_JUMP       2'd2
`define INST_LOAD_STORE 2'd3

`endif

// File: common/bp_pkg.sv
// ====================
// branch prediction types
// widths shared by predictor, checker and fetch
// ====================
`include "bp_defines.svh"

package bp_pkg;

    // instruction address
    typedef logic [31:0] pc_t;

    // branch target held in the target buffer
    typedef logic [31:0] target_t;

    // decoded instruction class
    typedef logic [1:0] inst_type_t;

    // table index, taken from the pc
    typedef logic [`BP_INDEX_MSB-`BP_INDEX_LSB:0] bp_index_t;

    // mispredict counter, wraps
    typedef logic [15:0] count_t;

endpackage

// File: common/bp_retire_if.sv
// ====================
// retire bundle
// retired instruction info plus its stored prediction
// ====================
`timescale 1ns/100ps

interface bp_retire_if;

    // class of the retiring instruction
    bp_pkg::inst_type_t inst_type;
    // address of the retiring instruction
    bp_pkg::pc_t        pc;
    // resolved outcome from execute
    logic               taken;
    bp_pkg::target_t    target;
    // history bit read back for this pc
    logic               pred_taken;

    // table side: takes the outcome, returns the old bit
    modport predictor (
        input  inst_type,
        input  pc,
        input  taken,
        input  target,
        output pred_taken
    );

    // checker side sees everything
    modport check (
        input inst_type,
        input pc,
        input taken,
        input target,
        input pred_taken
    );

endinterface

// File: logic/bp_top.sv
// ====================
// branch prediction top
// predictor, mispredict checker and fetch pc generator
// ====================
`timescale 1ns/100ps

module bp_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    // fetch and dispatch side
    input  logic               fetch_en,
    input  bp_pkg::inst_type_t dispatch_inst_type,
    // retire side
    input  bp_pkg::inst_type_t retire_inst_type,
    input  bp_pkg::pc_t        retire_pc,
    input  logic               retire_taken,
    input  bp_pkg::target_t    retire_target,
    // outputs
    output bp_pkg::pc_t        fetch_pc,
    output logic               prediction,
    output bp_pkg::target_t    predicted_target,
    output logic               redirect,
    output bp_pkg::pc_t        redirect_pc,
    output bp_pkg::count_t     mispredict_count
);

    // retire bundle between predictor and checker
    bp_retire_if retire_bus ();

    bp_pkg::target_t retire_pred_target;

    // outcome from the top ports
    // pred_taken comes back from the predictor
    assign retire_bus.inst_type = retire_inst_type;
    assign retire_bus.pc        = retire_pc;
    assign retire_bus.taken     = retire_taken;
    assign retire_bus.target    = retire_target;

    // lookup runs off the current fetch pc
    branch_predictor u_predictor (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .dispatch_inst_type (dispatch_inst_type),
        .dispatch_pc        (fetch_pc),
        .retire             (retire_bus.predictor),
        .prediction         (prediction),
        .predicted_target   (predicted_target),
        .retire_pred_target (retire_pred_target)
    );

    // redirect one edge after the retire
    mispredict_check u_checker (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .retire             (retire_bus.check),
        .retire_pred_target (retire_pred_target),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .mispredict_count   (mispredict_count)
    );

    fetch_pc_gen u_pc_gen (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .fetch_en         (fetch_en),
        .prediction       (prediction),
        .predicted_target (predicted_target),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .fetch_pc         (fetch_pc)
    );

endmodule

// File: logic/fetch_pc_gen.sv
// ====================
// fetch pc generator
// sequential, predicted and redirect next pc
// ====================
`timescale 1ns/100ps
`include "bp_defines.svh"

module fetch_pc_gen (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            fetch_en,
    input  logic            prediction,
    input  bp_pkg::target_t predicted_target,
    input  logic            redirect,
    input  bp_pkg::pc_t     redirect_pc,
    output bp_pkg::pc_t     fetch_pc
);

    bp_pkg::pc_t next_pc;

    // priority: redirect, then prediction, then pc + 4
    always_comb begin
        if (redirect) begin
            // wins even with fetch stalled
            next_pc = redirect_pc;
        end else if (fetch_en && prediction) begin
            next_pc = predicted_target;
        end else if (fetch_en) begin
            next_pc = fetch_pc + 32'd4;
        end else begin
            // stalled, hold
            next_pc = fetch_pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fetch_pc <= `BP_RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

// File: logic/mispredict_check.sv
// ====================
// mispredict checker
// compares retired branch with stored prediction
// registers redirect and counts mispredicts
// ====================
`timescale 1ns/100ps
`include "bp_defines.svh"

module mispredict_check (
    input  logic            i_clk,
    input  logic            i_rst_n,
    bp_retire_if.check      retire,
    input  bp_pkg::target_t retire_pred_target,
    output logic            redirect,
    output bp_pkg::pc_t     redirect_pc,
    output bp_pkg::count_t  mispredict_count
);

    logic        retire_is_branch;
    logic        dir_wrong;
    logic        tgt_wrong;
    logic        mispredict;
    bp_pkg::pc_t fix_pc;

    assign retire_is_branch = (retire.inst_type == `INST_BRANCH);

    // direction flipped against the history bit
    assign dir_wrong = (retire.pred_taken != retire.taken);

    // both taken but buffer held a stale target
    assign tgt_wrong = retire.pred_taken && retire.taken &&
                       (retire_pred_target != retire.target);

    assign mispredict = retire_is_branch && (dir_wrong || tgt_wrong);

    // where fetch should have gone
    // taken goes to target, else fall through
    assign fix_pc = retire.taken ? retire.target : (retire.pc + 32'd4);

    // redirect is a one-cycle pulse
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            redirect <= 1'b0;
        end else begin
            redirect <= mispredict;
        end
    end

    // redirect pc held until the next mispredict
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            redirect_pc <= '0;
        end else if (mispredict) begin
            redirect_pc <= fix_pc;
        end
    end

    // counter wraps at 16 bits
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mispredict_count <= '0;
        end else if (mispredict) begin
            mispredict_count <= mispredict_count + 16'd1;
        end
    end

endmodule
